// File: common/he_consts.svh
`ifndef HE_CONSTS_SVH
`define HE_CONSTS_SVH

////////////////////
// data widths
`define HE_COEF_W 30            // one coefficient, always below q
`define HE_WORD_W 32            // csr and memory data word
`define HE_ADDR_W 40            // memory byte address

////////////////////
// coefficient buffers
`define HE_MAX_N 1024           // deepest polynomial
`define HE_IDX_W 10             // log2 of HE_MAX_N

////////////////////
// csr map, word offsets
`define HE_CSR_ADDR_W 4
`define HE_CSR_Q      4'd0
`define HE_CSR_N      4'd1
`define HE_CSR_A_PTR  4'd2
`define HE_CSR_B_PTR  4'd3
`define HE_CSR_C_PTR  4'd4
`define HE_CSR_START  4'd5
`define HE_CSR_STATUS 4'd6

// completion word, written once per run
`define HE_DONE_ADDR   40'h30_0000
`define HE_DONE_WORD   32'hffff_ffff

`define HE_COEF_STRIDE 4        // bytes per coefficient in memory

`endif

// File: common/he_csr_pkg.sv
`include "he_consts.svh"

package he_csr_pkg;

   // host visible registers
   typedef enum logic [`HE_CSR_ADDR_W-1:0] {
      CSR_Q      = `HE_CSR_Q,
      CSR_N      = `HE_CSR_N,
      CSR_A_PTR  = `HE_CSR_A_PTR,
      CSR_B_PTR  = `HE_CSR_B_PTR,
      CSR_C_PTR  = `HE_CSR_C_PTR,
      CSR_START  = `HE_CSR_START,
      CSR_STATUS = `HE_CSR_STATUS
   } csr_idx_e;

   // one host access, valid is a single-cycle pulse
   typedef struct packed {
      logic                      valid;
      logic                      we;     // 1 write, 0 read
      logic [`HE_CSR_ADDR_W-1:0] addr;
      logic [`HE_WORD_W-1:0]     data;
   } csr_req_s;

   typedef struct packed {
      logic                  valid;
      logic [`HE_WORD_W-1:0] data;   // zero for writes
   } csr_resp_s;

   // run configuration, held as a level
   typedef struct packed {
      logic [`HE_COEF_W-1:0] q;
      logic [`HE_IDX_W:0]    n;      // 1 .. HE_MAX_N
      logic [`HE_WORD_W-1:0] a_ptr;
      logic [`HE_WORD_W-1:0] b_ptr;
      logic [`HE_WORD_W-1:0] c_ptr;  // also the result destination
   } he_cfg_s;

endpackage

// File: common/he_mem_pkg.sv
`include "he_consts.svh"

package he_mem_pkg;

   typedef enum logic {
      MEM_RD,
      MEM_WR
   } mem_op_e;

   // held until yumi
   typedef struct packed {
      logic                  valid;
      mem_op_e               op;
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_WORD_W-1:0] data;   // write data only
   } mem_cmd_s;

   // read data return, one per read
   typedef struct packed {
      logic                  valid;
      logic [`HE_WORD_W-1:0] data;
   } mem_resp_s;

   // which coefficient buffer the dma talks to
   typedef enum logic [1:0] {
      BUF_A,
      BUF_B,
      BUF_C
   } buf_sel_e;

endpackage

// File: design/he_coef_buffer.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_coef_buffer
(
   input  logic                  clk_i,
   input  logic                  we_i,
   input  logic [`HE_IDX_W-1:0]  idx_i,
   input  logic [`HE_COEF_W-1:0] wdata_i,
   output logic [`HE_COEF_W-1:0] rdata_o
);

   logic [`HE_COEF_W-1:0] mem_r [`HE_MAX_N];

   // one port, read data one cycle after the index
   always_ff @(posedge clk_i)
   begin
      if (we_i)
         mem_r[idx_i] <= wdata_i;
      rdata_o <= mem_r[idx_i];   // old contents on a write cycle
   end

endmodule

// File: design/he_csr_regs.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_csr_regs
   import he_csr_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  csr_req_s  csr_req_i,
   output csr_resp_s csr_resp_o,
   input  logic      busy_i,
   output he_cfg_s   cfg_o,
   output logic      start_o
);

   he_cfg_s               cfg_r;
   logic                  wr_en;
   logic                  rd_en;
   logic                  resp_valid_r;
   logic [`HE_WORD_W-1:0] resp_data_r;
   logic [`HE_WORD_W-1:0] rd_data;

   assign wr_en = csr_req_i.valid & csr_req_i.we;
   assign rd_en = csr_req_i.valid & ~csr_req_i.we;

   // a start while busy is acked but dropped here
   assign start_o = wr_en & (csr_idx_e'(csr_req_i.addr) == CSR_START) & ~busy_i;

   always_comb
   begin
      case (csr_idx_e'(csr_req_i.addr))
         CSR_Q:      rd_data = `HE_WORD_W'(cfg_r.q);
         CSR_N:      rd_data = `HE_WORD_W'(cfg_r.n);
         CSR_A_PTR:  rd_data = cfg_r.a_ptr;
         CSR_B_PTR:  rd_data = cfg_r.b_ptr;
         CSR_C_PTR:  rd_data = cfg_r.c_ptr;
         CSR_STATUS: rd_data = `HE_WORD_W'(busy_i);
         default:    rd_data = '0;   // start is write-only
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cfg_r        <= '0;
         resp_valid_r <= 1'b0;
      end
      else
      begin
         resp_valid_r <= csr_req_i.valid;   // every access answers next cycle
         if (wr_en)
         begin
            case (csr_idx_e'(csr_req_i.addr))
               CSR_Q:     cfg_r.q     <= csr_req_i.data[`HE_COEF_W-1:0];
               CSR_N:     cfg_r.n     <= csr_req_i.data[`HE_IDX_W:0];
               CSR_A_PTR: cfg_r.a_ptr <= csr_req_i.data;
               CSR_B_PTR: cfg_r.b_ptr <= csr_req_i.data;
               CSR_C_PTR: cfg_r.c_ptr <= csr_req_i.data;
               default:   ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      resp_data_r <= rd_en ? rd_data : '0;
   end

   assign csr_resp_o = '{valid: resp_valid_r, data: resp_data_r};
   assign cfg_o      = cfg_r;

endmodule

// File: design/he_sequencer.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_sequencer
   import he_csr_pkg::*;
   import he_mem_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  start_i,
   input  he_cfg_s               cfg_i,
   output logic                  busy_o,
   output logic                  dma_go_o,
   output mem_op_e               dma_op_o,
   output buf_sel_e              dma_sel_o,
   output logic [`HE_ADDR_W-1:0] dma_base_o,
   input  logic                  dma_done_i,
   output logic                  calc_go_o,
   input  logic                  calc_done_i,
   output mem_cmd_s              done_cmd_o,
   input  logic                  mem_cmd_yumi_i
);

   typedef enum logic [2:0] {
      IDLE,
      LOAD_A,
      LOAD_B,
      LOAD_C,
      CALC,
      STORE,     // buffer A back to c_ptr
      DONE
   } state_e;

   state_e state_r;
   state_e state_n;
   logic   enter_r;   // first cycle of a phase

   ////////////////////
   // phase stepping

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:    state_n = start_i ? LOAD_A : IDLE;
         LOAD_A:  state_n = dma_done_i ? LOAD_B : LOAD_A;
         LOAD_B:  state_n = dma_done_i ? LOAD_C : LOAD_B;
         LOAD_C:  state_n = dma_done_i ? CALC : LOAD_C;
         CALC:    state_n = calc_done_i ? STORE : CALC;
         STORE:   state_n = dma_done_i ? DONE : STORE;
         DONE:    state_n = mem_cmd_yumi_i ? IDLE : DONE;   // done word taken
         default: state_n = IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= IDLE;
         enter_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         enter_r <= (state_n != state_r);
      end
   end

   assign busy_o = (state_r != IDLE);

   // one kick per phase
   assign dma_go_o  = enter_r & (state_r inside {LOAD_A, LOAD_B, LOAD_C, STORE});
   assign calc_go_o = enter_r & (state_r == CALC);

   ////////////////////
   // dma setup per phase

   assign dma_op_o  = (state_r == STORE) ? MEM_WR : MEM_RD;
   assign dma_sel_o = (state_r == LOAD_B) ? BUF_B :
                      (state_r == LOAD_C) ? BUF_C : BUF_A;

   always_comb
   begin
      case (state_r)
         LOAD_B:  dma_base_o = `HE_ADDR_W'(cfg_i.b_ptr);
         LOAD_C,
         STORE:   dma_base_o = `HE_ADDR_W'(cfg_i.c_ptr);   // results overwrite C
         default: dma_base_o = `HE_ADDR_W'(cfg_i.a_ptr);
      endcase
   end

   // completion write, shares the memory port with the dma
   assign done_cmd_o = '{valid: (state_r == DONE),
                         op:    MEM_WR,
                         addr:  `HE_DONE_ADDR,
                         data:  `HE_DONE_WORD};

endmodule

// File: dma/he_dma_engine.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_dma_engine
   import he_mem_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  go_i,
   input  mem_op_e               op_i,
   input  buf_sel_e              sel_i,
   input  logic [`HE_ADDR_W-1:0] base_i,
   input  logic [`HE_IDX_W:0]    len_i,
   output logic                  done_o,
   output mem_cmd_s              mem_cmd_o,
   input  logic                  mem_cmd_yumi_i,
   input  mem_resp_s             mem_resp_i,
   output logic                  buf_we_o,
   output buf_sel_e              buf_sel_o,
   output logic [`HE_IDX_W-1:0]  buf_idx_o,
   output logic [`HE_COEF_W-1:0] buf_wdata_o,
   input  logic [`HE_COEF_W-1:0] buf_rdata_i
);

   typedef enum logic [2:0] {
      IDLE,
      RD_CMD,
      RD_WAIT,    // one read outstanding
      WR_FETCH,   // prime the buffer read
      WR_CMD
   } state_e;

   state_e                state_r;
   state_e                state_n;
   mem_op_e               op_r;
   buf_sel_e              sel_r;
   logic [`HE_ADDR_W-1:0] base_r;
   logic [`HE_IDX_W-1:0]  idx_r;
   logic                  done_r;
   logic                  last;

   assign last = ({1'b0, idx_r} == len_i - 1'b1);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:     state_n = !go_i ? IDLE : (op_i == MEM_RD) ? RD_CMD : WR_FETCH;
         RD_CMD:   state_n = mem_cmd_yumi_i ? RD_WAIT : RD_CMD;
         RD_WAIT:  state_n = !mem_resp_i.valid ? RD_WAIT : last ? IDLE : RD_CMD;
         WR_FETCH: state_n = WR_CMD;
         WR_CMD:   state_n = (mem_cmd_yumi_i && last) ? IDLE : WR_CMD;
         default:  state_n = IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= IDLE;
         idx_r   <= '0;
         done_r  <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         done_r  <= 1'b0;
         case (state_r)
            IDLE:
               idx_r <= '0;
            RD_WAIT:
               if (mem_resp_i.valid)
               begin
                  idx_r  <= idx_r + 1'b1;
                  done_r <= last;
               end
            WR_CMD:
               if (mem_cmd_yumi_i)
               begin
                  idx_r  <= idx_r + 1'b1;
                  done_r <= last;
               end
            default: ;
         endcase
      end
   end

   // transfer setup, captured at go
   always_ff @(posedge clk_i)
   begin
      if (go_i)
      begin
         op_r   <= op_i;
         sel_r  <= sel_i;
         base_r <= base_i;
      end
   end

   assign done_o = done_r;

   ////////////////////
   // memory side

   assign mem_cmd_o.valid = (state_r == RD_CMD) || (state_r == WR_CMD);
   assign mem_cmd_o.op    = op_r;
   assign mem_cmd_o.addr  = base_r + `HE_ADDR_W'(idx_r) * `HE_COEF_STRIDE;
   assign mem_cmd_o.data  = (state_r == WR_CMD) ? `HE_WORD_W'(buf_rdata_i) : '0;

   ////////////////////
   // buffer side

   assign buf_sel_o   = sel_r;
   assign buf_we_o    = (state_r == RD_WAIT) & mem_resp_i.valid;
   assign buf_wdata_o = mem_resp_i.data[`HE_COEF_W-1:0];

   // step the read one ahead once a write is taken, else hold the word
   assign buf_idx_o = (state_r == WR_CMD && mem_cmd_yumi_i) ? idx_r + 1'b1 : idx_r;

endmodule

// File: arith/he_pointwise_unit.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_pointwise_unit
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  go_i,
   input  logic [`HE_COEF_W-1:0] q_i,
   input  logic [`HE_IDX_W:0]    len_i,
   output logic [`HE_IDX_W-1:0]  idx_o,
   input  logic [`HE_COEF_W-1:0] a_i,
   input  logic [`HE_COEF_W-1:0] b_i,
   input  logic [`HE_COEF_W-1:0] c_i,
   output logic                  we_o,
   output logic [`HE_IDX_W-1:0]  widx_o,
   output logic [`HE_COEF_W-1:0] res_o,
   output logic                  done_o
);

   logic                    run_r;
   logic [`HE_IDX_W-1:0]    cnt_r;
   logic                    issue;
   logic                    last_issue;
   logic                    last_wr;
   logic                    v1_r;
   logic                    v2_r;
   logic                    v3_r;
   logic [`HE_IDX_W-1:0]    idx1_r;
   logic [`HE_IDX_W-1:0]    idx2_r;
   logic [`HE_IDX_W-1:0]    idx3_r;
   logic [`HE_COEF_W-1:0]   m2_r;
   logic [`HE_COEF_W-1:0]   c2_r;
   logic [`HE_COEF_W-1:0]   r3_r;
   logic [2*`HE_COEF_W-1:0] prod;
   logic [`HE_COEF_W:0]     sum;

   // write-back owns buffer A's only port, issue waits that cycle
   assign issue      = run_r & ~v3_r;
   assign last_issue = ({1'b0, cnt_r} == len_i - 1'b1);
   assign last_wr    = ({1'b0, idx3_r} == len_i - 1'b1);
   assign idx_o      = cnt_r;

   assign prod = a_i * b_i;     // full width product
   assign sum  = m2_r + c2_r;   // below 2q

   ////////////////////
   // issue and valids

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         run_r  <= 1'b0;
         cnt_r  <= '0;
         v1_r   <= 1'b0;
         v2_r   <= 1'b0;
         v3_r   <= 1'b0;
         done_o <= 1'b0;
      end
      else
      begin
         v1_r   <= issue;   // buffer read stage
         v2_r   <= v1_r;
         v3_r   <= v2_r;
         done_o <= v3_r & last_wr;   // last result just written
         if (go_i)
         begin
            run_r <= 1'b1;
            cnt_r <= '0;
         end
         else if (issue)
         begin
            cnt_r <= cnt_r + 1'b1;
            run_r <= ~last_issue;
         end
      end
   end

   ////////////////////
   // datapath

   always_ff @(posedge clk_i)
   begin
      idx1_r <= cnt_r;
      idx2_r <= idx1_r;
      m2_r   <= `HE_COEF_W'(prod % q_i);   // a*b mod q
      c2_r   <= c_i;
      idx3_r <= idx2_r;
      r3_r   <= `HE_COEF_W'(sum % q_i);    // + c mod q
   end

   assign we_o   = v3_r;
   assign widx_o = idx3_r;
   assign res_o  = r3_r;

endmodule

// File: design/he_accel_top.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_accel_top
   import he_csr_pkg::*;
   import he_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  csr_req_s  csr_req_i,
   output csr_resp_s csr_resp_o,
   output mem_cmd_s  mem_cmd_o,
   input  logic      mem_cmd_yumi_i,
   input  mem_resp_s mem_resp_i
);

   he_cfg_s               cfg;
   logic                  start;
   logic                  busy;
   logic                  dma_go;
   logic                  dma_done;
   mem_op_e               dma_op;
   buf_sel_e              dma_sel;
   logic [`HE_ADDR_W-1:0] dma_base;
   logic                  calc_go;
   logic                  calc_done;
   logic                  calc_phase_r;   // pointwise unit owns the buffers
   mem_cmd_s              dma_cmd;
   mem_cmd_s              done_cmd;

   logic                  dma_buf_we;
   buf_sel_e              dma_buf_sel;
   logic [`HE_IDX_W-1:0]  dma_buf_idx;
   logic [`HE_COEF_W-1:0] dma_buf_wdata;
   logic [`HE_COEF_W-1:0] dma_buf_rdata;

   logic [`HE_IDX_W-1:0]  pw_idx;
   logic                  pw_we;
   logic [`HE_IDX_W-1:0]  pw_widx;
   logic [`HE_COEF_W-1:0] pw_res;

   logic                  we_a;
   logic                  we_b;
   logic                  we_c;
   logic [`HE_IDX_W-1:0]  idx_a;
   logic [`HE_IDX_W-1:0]  idx_bc;
   logic [`HE_COEF_W-1:0] buf_wdata;
   logic [`HE_COEF_W-1:0] rdata_a;
   logic [`HE_COEF_W-1:0] rdata_b;
   logic [`HE_COEF_W-1:0] rdata_c;

   he_csr_regs he_csr_regs_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .csr_req_i  (csr_req_i),
      .csr_resp_o (csr_resp_o),
      .busy_i     (busy),
      .cfg_o      (cfg),
      .start_o    (start)
   );

   he_sequencer he_sequencer_i (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .start_i        (start),
      .cfg_i          (cfg),
      .busy_o         (busy),
      .dma_go_o       (dma_go),
      .dma_op_o       (dma_op),
      .dma_sel_o      (dma_sel),
      .dma_base_o     (dma_base),
      .dma_done_i     (dma_done),
      .calc_go_o      (calc_go),
      .calc_done_i    (calc_done),
      .done_cmd_o     (done_cmd),
      .mem_cmd_yumi_i (mem_cmd_yumi_i)
   );

   he_dma_engine he_dma_engine_i (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .go_i           (dma_go),
      .op_i           (dma_op),
      .sel_i          (dma_sel),
      .base_i         (dma_base),
      .len_i          (cfg.n),
      .done_o         (dma_done),
      .mem_cmd_o      (dma_cmd),
      .mem_cmd_yumi_i (mem_cmd_yumi_i),
      .mem_resp_i     (mem_resp_i),
      .buf_we_o       (dma_buf_we),
      .buf_sel_o      (dma_buf_sel),
      .buf_idx_o      (dma_buf_idx),
      .buf_wdata_o    (dma_buf_wdata),
      .buf_rdata_i    (dma_buf_rdata)
   );

   he_pointwise_unit he_pointwise_unit_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .go_i    (calc_go),
      .q_i     (cfg.q),
      .len_i   (cfg.n),
      .idx_o   (pw_idx),
      .a_i     (rdata_a),
      .b_i     (rdata_b),
      .c_i     (rdata_c),
      .we_o    (pw_we),
      .widx_o  (pw_widx),
      .res_o   (pw_res),
      .done_o  (calc_done)
   );

   ////////////////////
   // buffer port ownership

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         calc_phase_r <= 1'b0;
      else if (calc_go)
         calc_phase_r <= 1'b1;
      else if (calc_done)
         calc_phase_r <= 1'b0;
   end

   assign we_a   = calc_phase_r ? pw_we : dma_buf_we & (dma_buf_sel == BUF_A);
   assign we_b   = ~calc_phase_r & dma_buf_we & (dma_buf_sel == BUF_B);
   assign we_c   = ~calc_phase_r & dma_buf_we & (dma_buf_sel == BUF_C);
   assign idx_a  = !calc_phase_r ? dma_buf_idx : pw_we ? pw_widx : pw_idx;
   assign idx_bc = calc_phase_r ? pw_idx : dma_buf_idx;
   assign buf_wdata = calc_phase_r ? pw_res : dma_buf_wdata;

   assign dma_buf_rdata = (dma_buf_sel == BUF_A) ? rdata_a :
                          (dma_buf_sel == BUF_B) ? rdata_b : rdata_c;

   he_coef_buffer buf_a_i (
      .clk_i   (clk_i),
      .we_i    (we_a),
      .idx_i   (idx_a),
      .wdata_i (buf_wdata),
      .rdata_o (rdata_a)
   );

   he_coef_buffer buf_b_i (
      .clk_i   (clk_i),
      .we_i    (we_b),
      .idx_i   (idx_bc),
      .wdata_i (buf_wdata),
      .rdata_o (rdata_b)
   );

   he_coef_buffer buf_c_i (
      .clk_i   (clk_i),
      .we_i    (we_c),
      .idx_i   (idx_bc),
      .wdata_i (buf_wdata),
      .rdata_o (rdata_c)
   );

   ////////////////////
   // memory port, the two owners never overlap

   always_comb
   begin
      mem_cmd_o       = done_cmd.valid ? done_cmd : dma_cmd;
      mem_cmd_o.valid = dma_cmd.valid | done_cmd.valid;
   end

endmodule

// File: testbench/he_accel_properties.sv
`timescale 1ns/1ps

module he_accel_properties
   import he_csr_pkg::*;
   import he_mem_pkg::*;
(
   input logic      clk_i,
   input logic      reset_i,
   input csr_req_s  csr_req_i,
   input csr_resp_s csr_resp_i,
   input mem_cmd_s  mem_cmd_i,
   input logic      mem_cmd_yumi_i,
   input mem_cmd_s  dma_cmd_i,
   input mem_cmd_s  done_cmd_i
);

   ////////////////////
   // memory port

   // a waiting command may not move
   cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_cmd_i.valid && !mem_cmd_yumi_i |=> mem_cmd_i.valid && $stable(mem_cmd_i))
      else $error("memory command changed before it was accepted");

   one_owner: assert property (@(posedge clk_i) disable iff (reset_i)
      !(dma_cmd_i.valid && done_cmd_i.valid))   // dma and done write
      else $error("dma engine and sequencer drove the memory port together");

   ////////////////////
   // host port

   csr_answer: assert property (@(posedge clk_i) disable iff (reset_i)
      csr_req_i.valid |=> csr_resp_i.valid)
      else $error("csr request without a response one cycle later");

endmodule

bind he_accel_top he_accel_properties he_accel_properties_i (
   .clk_i          (clk_i),
   .reset_i        (reset_i),
   .csr_req_i      (csr_req_i),
   .csr_resp_i     (csr_resp_o),
   .mem_cmd_i      (mem_cmd_o),
   .mem_cmd_yumi_i (mem_cmd_yumi_i),
   .dma_cmd_i      (dma_cmd),
   .done_cmd_i     (done_cmd)
);

// File: testbench/he_accel_tb.sv
`timescale 1ns/1ps
`include "he_consts.svh"

module he_accel_tb
   import he_csr_pkg::*;
   import he_mem_pkg::*;
();

   localparam int RUN_TIMEOUT  = 400000;   // cycles per run, n = 1024 under full delay
   localparam int RESP_TIMEOUT = 8;

   logic      clk;
   logic      reset;
   csr_req_s  csr_req;
   csr_resp_s csr_resp;
   mem_cmd_s  mem_cmd;
   logic      mem_yumi;
   mem_resp_s mem_resp;

   logic [`HE_WORD_W-1:0] mem [logic [`HE_ADDR_W-1:0]];   // sparse memory
   int                    done_words;   // accepted writes to the done address
   int                    case_fd;
   int                    tests;
   int                    failed_tests;
   int                    checks;
   int                    errors;
   bit                    stop_run;

   he_accel_top he_accel_top_i (
      .clk_i          (clk),
      .reset_i        (reset),
      .csr_req_i      (csr_req),
      .csr_resp_o     (csr_resp),
      .mem_cmd_o      (mem_cmd),
      .mem_cmd_yumi_i (mem_yumi),
      .mem_resp_i     (mem_resp)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////
   // reference helpers

   // unwritten words, varies with every address bit
   function automatic logic [`HE_WORD_W-1:0] fill_word(input logic [`HE_ADDR_W-1:0] addr);
      return `HE_WORD_W'(addr) ^ `HE_WORD_W'(addr >> 17) ^ 32'h3c5a_0000;
   endfunction

   function automatic logic [`HE_WORD_W-1:0] mem_peek(input logic [`HE_ADDR_W-1:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      return fill_word(addr);
   endfunction

   // generated coefficient, below q
   function automatic logic [`HE_WORD_W-1:0] coef_pattern(input logic [`HE_ADDR_W-1:0] addr,
                                                          input longint unsigned q);
      longint unsigned h;
      h = 64'(addr) * 64'h9e37_79b9 + (64'(addr) >> 9);
      return `HE_WORD_W'(h % q);
   endfunction

   // (a*b mod q + c) mod q
   function automatic logic [`HE_WORD_W-1:0] model_result(input longint unsigned a,
                                                          input longint unsigned b,
                                                          input longint unsigned c,
                                                          input longint unsigned q);
      return `HE_WORD_W'(((a * b) % q + c) % q);
   endfunction

   // next line that is neither blank nor a comment
   function automatic bit next_line(input int fd, output string line);
      int got;
      line = "";
      while (!$feof(fd))
      begin
         got = $fgets(line, fd);
         if (got > 0 && line.len() > 1 && line.getc(0) != "#")
            return 1'b1;
      end
      return 1'b0;
   endfunction

   ////////////////////
   // memory model

   initial
   begin : memory_model
      int                    hold;   // yumi delay left, -1 when none drawn
      int                    lat;
      bit                    rd_pending;
      logic [`HE_ADDR_W-1:0] rd_addr;
      hold       = -1;
      lat        = 0;
      rd_pending = 1'b0;
      rd_addr    = '0;
      mem_yumi   = 1'b0;
      mem_resp   = '0;
      void'($urandom(26));
      forever
      begin
         @(posedge clk);
         #1;
         mem_resp = '0;
         if (rd_pending)
         begin
            lat = lat - 1;
            if (lat == 0)
            begin
               mem_resp.valid = 1'b1;
               mem_resp.data  = mem_peek(rd_addr);
               rd_pending     = 1'b0;
            end
         end
         mem_yumi = 1'b0;
         if (mem_cmd.valid && !reset)
         begin
            if (hold < 0)
               hold = $urandom_range(3, 0);
            if (hold == 0)
            begin
               mem_yumi = 1'b1;   // taken at the next edge
               hold     = -1;
               if (mem_cmd.op == MEM_WR)
               begin
                  mem[mem_cmd.addr] = mem_cmd.data;
                  if (mem_cmd.addr == `HE_DONE_ADDR)
                     done_words++;
               end
               else
               begin
                  rd_pending = 1'b1;
                  rd_addr    = mem_cmd.addr;
                  lat        = $urandom_range(4, 1) + 1;   // plus the accept cycle
               end
            end
            else
               hold = hold - 1;
         end
      end
   end

   ////////////////////
   // host side and checks

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0d ns: %s, got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic csr_access(input logic we, input logic [`HE_CSR_ADDR_W-1:0] addr,
                             input logic [`HE_WORD_W-1:0] wdata,
                             output logic [`HE_WORD_W-1:0] rdata);
      int waited;
      waited = 0;
      rdata  = '0;
      @(posedge clk);
      #1;
      csr_req = '{valid: 1'b1, we: we, addr: addr, data: wdata};
      @(posedge clk);
      #1;
      csr_req = '0;
      while (!csr_resp.valid && waited < RESP_TIMEOUT)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!csr_resp.valid)
      begin
         $display("timeout: the CSR at offset %0d never answered", addr);
         errors++;
         stop_run = 1'b1;
      end
      else
         rdata = csr_resp.data;
   endtask

   task automatic csr_write(input logic [`HE_CSR_ADDR_W-1:0] addr,
                            input logic [`HE_WORD_W-1:0] data);
      logic [`HE_WORD_W-1:0] unused;
      csr_access(1'b1, addr, data, unused);
   endtask

   task automatic csr_read(input logic [`HE_CSR_ADDR_W-1:0] addr,
                           output logic [`HE_WORD_W-1:0] data);
      csr_access(1'b0, addr, '0, data);
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else
      begin
         failed_tests++;
         $display("test %s: FAIL, %0d errors", name, errors - err_before);
      end
   endtask

   task automatic csr_readback_test();
      logic [`HE_WORD_W-1:0] rdata;
      int                    err_before;
      err_before = errors;
      csr_read(CSR_STATUS, rdata);
      check_equal("status after reset", rdata, 0);
      csr_write(CSR_Q, 32'h2abc_def1);
      csr_write(CSR_N, 32'd777);
      csr_write(CSR_A_PTR, 32'h1234_5678);
      csr_write(CSR_B_PTR, 32'hcafe_0004);
      csr_write(CSR_C_PTR, 32'h0000_fff0);
      csr_read(CSR_Q, rdata);
      check_equal("q readback", rdata, 32'h2abc_def1);
      csr_read(CSR_N, rdata);
      check_equal("n readback", rdata, 32'd777);
      csr_read(CSR_A_PTR, rdata);
      check_equal("a_ptr readback", rdata, 32'h1234_5678);
      csr_read(CSR_B_PTR, rdata);
      check_equal("b_ptr readback", rdata, 32'hcafe_0004);
      csr_read(CSR_C_PTR, rdata);
      check_equal("c_ptr readback", rdata, 32'h0000_fff0);
      report_test("csr readback", err_before);
   endtask

   task automatic run_case(input int idx, input int unsigned q, input int unsigned n,
                           input int unsigned a_ptr, input int unsigned b_ptr,
                           input int unsigned c_ptr, input int unsigned gen);
      string                 line;
      int unsigned           a;
      int unsigned           b;
      int unsigned           c;
      int unsigned           e;
      logic [`HE_WORD_W-1:0] exp_res [$];
      logic [`HE_WORD_W-1:0] rdata;
      logic [`HE_ADDR_W-1:0] a_addr;
      logic [`HE_ADDR_W-1:0] b_addr;
      logic [`HE_ADDR_W-1:0] c_addr;
      int                    i;
      int                    waited;
      int                    runs_before;
      int                    err_before;
      string                 name;
      err_before = errors;
      name       = $sformatf("case %0d (q=%0d n=%0d)", idx, q, n);

      // stage A, B and C, keep the expected results aside
      for (i = 0; i < n && !stop_run; i++)
      begin
         a_addr = `HE_ADDR_W'(a_ptr) + `HE_ADDR_W'(i) * `HE_COEF_STRIDE;
         b_addr = `HE_ADDR_W'(b_ptr) + `HE_ADDR_W'(i) * `HE_COEF_STRIDE;
         c_addr = `HE_ADDR_W'(c_ptr) + `HE_ADDR_W'(i) * `HE_COEF_STRIDE;
         if (gen != 0)
         begin
            a = coef_pattern(a_addr, q);
            b = coef_pattern(b_addr, q);
            c = coef_pattern(c_addr, q);
            e = model_result(a, b, c, q);
         end
         else if (!next_line(case_fd, line) || $sscanf(line, "%d %d %d %d", a, b, c, e) != 4)
         begin
            $display("the case file has too few coefficient lines for case %0d", idx);
            errors++;
            stop_run = 1'b1;
         end
         mem[a_addr] = a;
         mem[b_addr] = b;
         mem[c_addr] = c;
         exp_res.push_back(e);
      end

      if (!stop_run)
      begin
         mem.delete(`HE_DONE_ADDR);
         runs_before = done_words;
         csr_write(CSR_Q, q);
         csr_write(CSR_N, n);
         csr_write(CSR_A_PTR, a_ptr);
         csr_write(CSR_B_PTR, b_ptr);
         csr_write(CSR_C_PTR, c_ptr);
         csr_write(CSR_START, 32'd1);
         csr_write(CSR_START, 32'd1);   // lands mid-run, must be dropped
         csr_read(CSR_STATUS, rdata);
         check_equal("status during run", rdata, 1);

         waited = 0;
         while (done_words == runs_before && waited < RUN_TIMEOUT)
         begin
            @(negedge clk);
            waited++;
         end
         if (done_words == runs_before)
         begin
            $display("timeout: case %0d never wrote its done word", idx);
            errors++;
            stop_run = 1'b1;
         end
         else
         begin
            check_equal("done word", mem_peek(`HE_DONE_ADDR), `HE_DONE_WORD);
            csr_read(CSR_STATUS, rdata);
            check_equal("status after run", rdata, 0);
            check_equal("done words per run", done_words - runs_before, 1);
            for (i = 0; i < n; i++)
            begin
               c_addr = `HE_ADDR_W'(c_ptr) + `HE_ADDR_W'(i) * `HE_COEF_STRIDE;
               check_equal($sformatf("case %0d result[%0d]", idx, i), mem_peek(c_addr),
                           exp_res[i]);
            end
         end
      end
      report_test(name, err_before);
   endtask

   ////////////////////
   // main flow

   initial
   begin : main
      string       line;
      int unsigned q;
      int unsigned n;
      int unsigned a_ptr;
      int unsigned b_ptr;
      int unsigned c_ptr;
      int unsigned gen;
      int          case_idx;
      reset        = 1'b1;
      csr_req      = '0;
      done_words   = 0;
      tests        = 0;
      failed_tests = 0;
      checks       = 0;
      errors       = 0;
      stop_run     = 1'b0;
      case_idx     = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      csr_readback_test();

      case_fd = $fopen("testbench/he_cases.txt", "r");
      if (case_fd == 0)
      begin
         $display("cannot open the case file testbench/he_cases.txt");
         errors++;
      end
      else
      begin
         while (!stop_run && next_line(case_fd, line))
         begin
            if ($sscanf(line, "case %d %d %d %d %d %d", q, n, a_ptr, b_ptr, c_ptr, gen) == 6)
            begin
               case_idx++;
               run_case(case_idx, q, n, a_ptr, b_ptr, c_ptr, gen);
            end
         end
         $fclose(case_fd);
      end

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: testbench/he_cases.txt
# case line: case q n a_ptr b_ptr c_ptr gen, all decimal
# gen 0: n lines follow with a b c expected; gen 1: coefficients come from an address pattern
case 17 4 4096 8192 12288 0
3 5 2 0
16 16 10 11
7 8 1 6
0 9 4 4
case 1000000007 5 16384 20480 24576 0
1000000006 1000000006 1000000006 0
1000000006 2 5 3
123456 1000 7 123456007
0 42 1000000006 1000000006
65536 65536 0 294967268
# single coefficient, adjacent pointers
case 97 1 28672 28676 28680 0
10 20 30 36
# full depth and a short odd length
case 12289 1024 65536 131072 196608 1
case 3329 33 262144 266240 270336 1

// File: files.f
+incdir+common
common/he_csr_pkg.sv
common/he_mem_pkg.sv
design/he_coef_buffer.sv
design/he_csr_regs.sv
design/he_sequencer.sv
dma/he_dma_engine.sv
arith/he_pointwise_unit.sv
design/he_accel_top.sv
testbench/he_accel_properties.sv
testbench/he_accel_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module he_accel_tb -f files.f
out=$(./obj_dir/Vhe_accel_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'sim passed'
